//--- hw/l2_cache_pkg.sv
// L2 cache shared definitions
`default_nettype none

package l2_cache_pkg;

    // tag sits above the set index
    localparam int ADDR_W  = 16;
    localparam int INDEX_W = 4;
    localparam int TAG_W   = ADDR_W - INDEX_W;
    localparam int SETS    = 16;

    // associativity
    localparam int WAYS    = 4;
    localparam int WAY_W   = 2;

    // one word per line
    localparam int DATA_W  = 32;

    // tree pseudo-LRU with bit 2 as root
    localparam int PLRU_W  = 3;

    // idle cycles before the eviction buffer drains
    localparam int DRAIN_W     = 3;
    localparam int DRAIN_DELAY = 7;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [DATA_W-1:0]  word_t;
    typedef logic [WAY_W-1:0]   way_t;
    typedef logic [WAYS-1:0]    way_mask_t;
    typedef logic [PLRU_W-1:0]  plru_t;
    typedef logic [DRAIN_W-1:0] drain_cnt_t;

    // cache controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        FILL,
        EVICT,
        DRAIN
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/l2_tag_lookup.sv
// L2 tag lookup and replacement
`timescale 1ns/1ps
`default_nettype none

module l2_tag_lookup (
    input  logic                 clk,
    input  logic                 rst,
    input  l2_cache_pkg::addr_t  adr,
    input  logic                 plru_update,
    input  logic                 fill,
    input  logic                 mark_dirty,
    input  logic                 invalidate_victim,
    output logic                 hit,
    output l2_cache_pkg::way_t   hit_way,
    output l2_cache_pkg::way_t   victim_way,
    output logic                 victim_invalid,
    output logic                 victim_dirty,
    output l2_cache_pkg::tag_t   victim_tag
);
    import l2_cache_pkg::*;

    // per-set bookkeeping
    tag_t      tag_mem   [SETS][WAYS];
    way_mask_t valid_mem [SETS];
    way_mask_t dirty_mem [SETS];
    plru_t     plru_mem  [SETS];

    index_t    idx;
    tag_t      req_tag;
    way_mask_t set_valid;
    way_mask_t way_match;
    plru_t     set_plru;
    plru_t     plru_next;

    assign idx       = adr[INDEX_W-1:0];
    assign req_tag   = adr[ADDR_W-1:INDEX_W];
    assign set_valid = valid_mem[idx];
    assign set_plru  = plru_mem[idx];

    // compare against every way of the set
    always_comb
    begin
        for (int i = 0; i < WAYS; i++)
        begin
            way_match[i] = set_valid[i] && (tag_mem[idx][i] == req_tag);
        end
    end

    assign hit = |way_match;

    // encode the matching way
    always_comb
    begin
        hit_way = '0;
        for (int i = 0; i < WAYS; i++)
        begin
            if (way_match[i])
                hit_way = way_t'(i);
        end
    end

    // victim is the lowest invalid way or the tree choice
    assign victim_invalid = ~&set_valid;

    always_comb
    begin
        if (victim_invalid)
        begin
            victim_way = '0;
            // scan downwards so the lowest invalid way wins
            for (int i = WAYS - 1; i >= 0; i--)
            begin
                if (!set_valid[i])
                    victim_way = way_t'(i);
            end
        end
        else if (!set_plru[2])
            victim_way = set_plru[0] ? 2'd2 : 2'd3;
        else
            victim_way = set_plru[1] ? 2'd0 : 2'd1;
    end

    assign victim_dirty = set_valid[victim_way] && dirty_mem[idx][victim_way];
    assign victim_tag   = tag_mem[idx][victim_way];

    // tree bits pointed away from the way just used
    always_comb
    begin
        plru_next = set_plru;
        case (hit_way)
            2'd0: plru_next = {1'b0, 1'b0, set_plru[0]};
            2'd1: plru_next = {1'b0, 1'b1, set_plru[0]};
            2'd2: plru_next = {1'b1, set_plru[1], 1'b0};
            default: plru_next = {1'b1, set_plru[1], 1'b1};
        endcase
    end

    // tag install on a fill
    always_ff @(posedge clk)
    begin
        if (fill)
            tag_mem[idx][victim_way] <= req_tag;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < SETS; s++)
            begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
                plru_mem[s]  <= '0;
            end
        end
        else
        begin
            if (plru_update)
                plru_mem[idx] <= plru_next;
            if (mark_dirty)
                dirty_mem[idx][hit_way] <= 1'b1;
            // fill lands clean
            if (fill)
            begin
                valid_mem[idx][victim_way] <= 1'b1;
                dirty_mem[idx][victim_way] <= 1'b0;
            end
            // victim now lives in the eviction buffer
            if (invalidate_victim)
            begin
                valid_mem[idx][victim_way] <= 1'b0;
                dirty_mem[idx][victim_way] <= 1'b0;
            end
        end
    end

    // a tag may sit in only one way of a set
    a_one_match: assert property (@(posedge clk) disable iff (rst) $onehot0(way_match));

endmodule

`default_nettype wire

//--- hw/l2_cache_control.sv
// L2 cache controller
`timescale 1ns/1ps
`default_nettype none

module l2_cache_control (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  l2_cache_pkg::addr_t  adr,
    input  logic                 hit,
    input  logic                 victim_dirty,
    input  logic                 victim_invalid,
    input  logic                 ewb_full,
    input  logic                 ewb_hit,
    input  l2_cache_pkg::addr_t  ewb_adr,
    input  logic                 mem_ack,
    output logic                 ack,
    output logic                 plru_update,
    output logic                 fill,
    output logic                 mark_dirty,
    output logic                 invalidate_victim,
    output logic                 write_hit,
    output logic                 ewb_load,
    output logic                 ewb_write,
    output logic                 ewb_release,
    output logic                 mem_cyc,
    output logic                 mem_stb,
    output logic                 mem_we,
    output l2_cache_pkg::addr_t  mem_adr
);
    import l2_cache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    drain_cnt_t  drain_cnt;
    logic        req;

    assign req = cyc && stb;

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                // cpu request beats the drain
                if (req)
                    next_state = LOOKUP;
                else if (ewb_full && (drain_cnt == '0))
                    next_state = DRAIN;
            end
            LOOKUP:
            begin
                if (ewb_hit || hit)
                    next_state = IDLE;
                else if (victim_invalid || !victim_dirty)
                    next_state = FILL;
                else if (!ewb_full)
                    next_state = EVICT;
                else
                    next_state = DRAIN;
            end
            FILL:
            begin
                // replay the lookup once the word is in
                if (mem_ack)
                    next_state = LOOKUP;
            end
            EVICT:
            begin
                next_state = FILL;
            end
            DRAIN:
            begin
                // back to a pending request or to idle
                if (mem_ack)
                    next_state = req ? LOOKUP : IDLE;
            end
            default:
            begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= next_state;
    end

    // idle countdown for the eviction buffer
    always_ff @(posedge clk)
    begin
        if (rst || (state == LOOKUP) || ((state == DRAIN) && mem_ack))
            drain_cnt <= drain_cnt_t'(DRAIN_DELAY);
        else if ((state == IDLE) && ewb_full && !req && (drain_cnt != '0))
            drain_cnt <= drain_cnt - 1'b1;
    end

    // cpu response with the buffer match first
    assign ack       = (state == LOOKUP) && (ewb_hit || hit);
    assign ewb_write = (state == LOOKUP) && ewb_hit && we;

    // cache hit bookkeeping
    assign plru_update = (state == LOOKUP) && !ewb_hit && hit;
    assign write_hit   = plru_update && we;
    assign mark_dirty  = plru_update && we;

    // install from memory on the fill beat
    assign fill = (state == FILL) && mem_ack;

    // dirty victim moves into the buffer
    assign ewb_load          = (state == EVICT);
    assign invalidate_victim = (state == EVICT);

    assign ewb_release = (state == DRAIN) && mem_ack;

    // memory master reads on fill and writes on drain
    assign mem_cyc = (state == FILL) || (state == DRAIN);
    assign mem_stb = mem_cyc;
    assign mem_we  = (state == DRAIN);
    assign mem_adr = (state == DRAIN) ? ewb_adr : adr;

    // idle always separates two responses
    a_ack_gap: assert property (@(posedge clk) disable iff (rst) ack |=> !ack);

    // buffer holds a single entry
    a_load_empty: assert property (@(posedge clk) disable iff (rst) !(ewb_load && ewb_full));

endmodule

`default_nettype wire

//--- hw/l2_data_store.sv
// L2 cache data arrays
`timescale 1ns/1ps
`default_nettype none

module l2_data_store (
    input  logic                 clk,
    input  l2_cache_pkg::addr_t  adr,
    input  l2_cache_pkg::word_t  dat_w,
    input  l2_cache_pkg::word_t  mem_dat_r,
    input  l2_cache_pkg::way_t   hit_way,
    input  l2_cache_pkg::way_t   victim_way,
    input  logic                 write_hit,
    input  logic                 fill,
    input  logic                 ewb_hit,
    input  l2_cache_pkg::word_t  ewb_data,
    output l2_cache_pkg::word_t  dat_r,
    output l2_cache_pkg::word_t  victim_data
);
    import l2_cache_pkg::*;

    // one word per way per set
    word_t  data_mem [WAYS][SETS];

    index_t idx;

    assign idx = adr[INDEX_W-1:0];

    // cpu write on a hit and memory word on a fill
    always_ff @(posedge clk)
    begin
        if (write_hit)
            data_mem[hit_way][idx] <= dat_w;
        if (fill)
            data_mem[victim_way][idx] <= mem_dat_r;
    end

    // buffer word overrides the arrays
    always_comb
    begin
        if (ewb_hit)
            dat_r = ewb_data;
        else
            dat_r = data_mem[hit_way][idx];
    end

    // word headed for the eviction buffer
    assign victim_data = data_mem[victim_way][idx];

endmodule

`default_nettype wire

//--- hw/l2_evict_buffer.sv
// L2 eviction write buffer
`timescale 1ns/1ps
`default_nettype none

module l2_evict_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  l2_cache_pkg::addr_t  adr,
    input  l2_cache_pkg::word_t  dat_w,
    input  l2_cache_pkg::tag_t   victim_tag,
    input  l2_cache_pkg::word_t  victim_data,
    input  logic                 ewb_load,
    input  logic                 ewb_write,
    input  logic                 ewb_release,
    output logic                 ewb_full,
    output logic                 ewb_hit,
    output l2_cache_pkg::addr_t  ewb_adr,
    output l2_cache_pkg::word_t  ewb_data
);
    import l2_cache_pkg::*;

    logic  entry_valid;
    addr_t entry_adr;
    word_t entry_data;

    // entry occupancy
    always_ff @(posedge clk)
    begin
        if (rst)
            entry_valid <= 1'b0;
        else if (ewb_load)
            entry_valid <= 1'b1;
        else if (ewb_release)
            entry_valid <= 1'b0;
    end

    // victim address rebuilt from its tag and the current set
    always_ff @(posedge clk)
    begin
        if (ewb_load)
            entry_adr <= {victim_tag, adr[INDEX_W-1:0]};
    end

    // cpu writes that match land here
    always_ff @(posedge clk)
    begin
        if (ewb_load)
            entry_data <= victim_data;
        else if (ewb_write)
            entry_data <= dat_w;
    end

    assign ewb_full = entry_valid;
    assign ewb_hit  = entry_valid && (adr == entry_adr);
    assign ewb_adr  = entry_adr;
    assign ewb_data = entry_data;

endmodule

`default_nettype wire

//--- hw/l2_cache_top.sv
// L2 cache top level
`timescale 1ns/1ps
`default_nettype none

module l2_cache_top (
    input  logic                 clk,
    input  logic                 rst,
    // cpu side wishbone slave
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  l2_cache_pkg::addr_t  adr,
    input  l2_cache_pkg::word_t  dat_w,
    output logic                 ack,
    output l2_cache_pkg::word_t  dat_r,
    // memory side wishbone master
    output logic                 mem_cyc,
    output logic                 mem_stb,
    output logic                 mem_we,
    output l2_cache_pkg::addr_t  mem_adr,
    output l2_cache_pkg::word_t  mem_dat_w,
    input  logic                 mem_ack,
    input  l2_cache_pkg::word_t  mem_dat_r
);
    import l2_cache_pkg::*;

    // lookup results
    logic  hit;
    way_t  hit_way;
    way_t  victim_way;
    logic  victim_invalid;
    logic  victim_dirty;
    tag_t  victim_tag;
    word_t victim_data;

    // controller strobes
    logic  plru_update;
    logic  fill;
    logic  mark_dirty;
    logic  invalidate_victim;
    logic  write_hit;
    logic  ewb_load;
    logic  ewb_write;
    logic  ewb_release;

    // eviction buffer state
    logic  ewb_full;
    logic  ewb_hit;
    addr_t ewb_adr;
    word_t ewb_data;

    l2_tag_lookup u_tag_lookup (
        .clk(clk), .rst(rst), .adr(adr),
        .plru_update(plru_update), .fill(fill), .mark_dirty(mark_dirty),
        .invalidate_victim(invalidate_victim),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
        .victim_invalid(victim_invalid), .victim_dirty(victim_dirty),
        .victim_tag(victim_tag)
    );

    l2_cache_control u_control (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .hit(hit), .victim_dirty(victim_dirty), .victim_invalid(victim_invalid),
        .ewb_full(ewb_full), .ewb_hit(ewb_hit), .ewb_adr(ewb_adr), .mem_ack(mem_ack),
        .ack(ack), .plru_update(plru_update), .fill(fill), .mark_dirty(mark_dirty),
        .invalidate_victim(invalidate_victim), .write_hit(write_hit),
        .ewb_load(ewb_load), .ewb_write(ewb_write), .ewb_release(ewb_release),
        .mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we), .mem_adr(mem_adr)
    );

    l2_evict_buffer u_evict_buffer (
        .clk(clk), .rst(rst), .adr(adr), .dat_w(dat_w),
        .victim_tag(victim_tag), .victim_data(victim_data),
        .ewb_load(ewb_load), .ewb_write(ewb_write), .ewb_release(ewb_release),
        .ewb_full(ewb_full), .ewb_hit(ewb_hit), .ewb_adr(ewb_adr), .ewb_data(ewb_data)
    );

    l2_data_store u_data_store (
        .clk(clk), .adr(adr), .dat_w(dat_w), .mem_dat_r(mem_dat_r),
        .hit_way(hit_way), .victim_way(victim_way),
        .write_hit(write_hit), .fill(fill),
        .ewb_hit(ewb_hit), .ewb_data(ewb_data),
        .dat_r(dat_r), .victim_data(victim_data)
    );

    // drain writes come straight from the buffer
    assign mem_dat_w = ewb_data;

endmodule

`default_nettype wire

//--- testbench/l2_cache_tb.sv
// L2 cache testbench
`timescale 1ns/1ps
`default_nettype none

module l2_cache_tb;
    import l2_cache_pkg::*;

    localparam int VEC_LINES  = 64;
    localparam int VEC_FIELDS = 5;

    // cpu side
    logic  clk = 1'b0;
    logic  rst = 1'b1;
    logic  cyc = 1'b0;
    logic  stb = 1'b0;
    logic  we = 1'b0;
    addr_t adr = '0;
    word_t dat_w = '0;
    logic  ack;
    word_t dat_r;

    // memory side
    logic  mem_cyc;
    logic  mem_stb;
    logic  mem_we;
    addr_t mem_adr;
    word_t mem_dat_w;
    logic  mem_ack = 1'b0;
    word_t mem_dat_r = '0;

    // memory model state
    word_t mem_array [0:65535];
    int    mem_reads = 0;
    int    mem_wait = 0;
    logic  mem_busy = 1'b0;

    logic [31:0] vec [0:VEC_LINES*VEC_FIELDS-1];
    int          cycle_count = 0;
    int          cycle_limit = 0;
    logic        started = 1'b0;

    l2_cache_top UUT (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .ack(ack), .dat_r(dat_r),
        .mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we), .mem_adr(mem_adr),
        .mem_dat_w(mem_dat_w), .mem_ack(mem_ack), .mem_dat_r(mem_dat_r)
    );

    always #4 clk = ~clk;

    // memory fill pattern
    function automatic word_t mem_hash(input addr_t a);
        return {~a, a};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // one wishbone request held until ack
    task automatic bus_access(input logic write, input addr_t a, input word_t wdata,
                              output word_t rdata);
        @(posedge clk);
        cyc     <= 1'b1;
        stb     <= 1'b1;
        we      <= write;
        adr     <= a;
        dat_w   <= wdata;
        started = 1'b1;
        @(negedge clk);
        while (!ack)
            @(negedge clk);
        rdata = dat_r;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    // memory slave acks after 1 to 4 cycles
    always @(posedge clk)
    begin
        if (rst)
        begin
            mem_ack <= 1'b0;
            mem_busy = 1'b0;
            for (int i = 0; i < 65536; i++)
                mem_array[i] = mem_hash(addr_t'(i));
        end
        else if (mem_ack)
            mem_ack <= 1'b0;
        else if (mem_cyc && mem_stb)
        begin
            if (!mem_busy)
            begin
                mem_busy = 1'b1;
                mem_wait = $urandom % 4;
            end
            if (mem_wait == 0)
            begin
                mem_busy = 1'b0;
                mem_ack <= 1'b1;
                if (mem_we)
                    mem_array[mem_adr] = mem_dat_w;
                else
                begin
                    mem_dat_r <= mem_array[mem_adr];
                    mem_reads++;
                end
            end
            else
                mem_wait = mem_wait - 1;
        end
    end

    // bus quiet until the first request
    always @(negedge clk)
    begin
        if (!rst && !started)
        begin
            compare_value("ack", 32'(ack), 32'd0);
            compare_value("mem_cyc", 32'(mem_cyc), 32'd0);
            compare_value("mem_stb", 32'(mem_stb), 32'd0);
            compare_value("mem_we", 32'(mem_we), 32'd0);
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $fatal(1);
        end
    end

    initial
    begin
        int         line;
        int         idle;
        int         reads_before;
        logic [3:0] op;
        addr_t      a;
        word_t      wdata;
        word_t      exp_data;
        word_t      rdata;

        void'($urandom(69));
        $readmemh("testbench/cache_input.txt", vec);
        // cycle budget from the vector list
        line = 0;
        while (line < VEC_LINES && vec[line*VEC_FIELDS][3:0] != 4'hf)
        begin
            cycle_limit = cycle_limit + 80 + int'(vec[line*VEC_FIELDS+4]);
            line++;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        line = 0;
        op = vec[0][3:0];
        while (line < VEC_LINES && op != 4'hf)
        begin
            a        = vec[line*VEC_FIELDS+1][15:0];
            wdata    = vec[line*VEC_FIELDS+2];
            exp_data = vec[line*VEC_FIELDS+3];
            idle     = int'(vec[line*VEC_FIELDS+4]);
            case (op)
                4'h0:
                begin
                end
                4'h1:
                begin
                    bus_access(1'b0, a, '0, rdata);
                    compare_value("dat_r", rdata, exp_data);
                end
                4'h2:
                begin
                    bus_access(1'b1, a, wdata, rdata);
                end
                4'h3:
                begin
                    reads_before = mem_reads;
                    bus_access(1'b0, a, '0, rdata);
                    compare_value("dat_r", rdata, exp_data);
                    // a hit must not touch memory
                    compare_value("mem_reads", mem_reads, reads_before);
                end
                4'h4:
                begin
                    @(negedge clk);
                    compare_value("mem_array", mem_array[a], exp_data);
                end
                default:
                begin
                    $display("unknown operation %h on vector line %0d", op, line);
                    $display("Something failed");
                    $fatal(1);
                end
            endcase
            repeat (idle) @(posedge clk);
            line++;
            op = vec[line*VEC_FIELDS][3:0];
        end

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
hw/l2_cache_pkg.sv
hw/l2_tag_lookup.sv
hw/l2_cache_control.sv
hw/l2_data_store.sv
hw/l2_evict_buffer.sv
hw/l2_cache_top.sv
testbench/l2_cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the l2 cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
    --top-module l2_cache_tb -o l2_cache_sim \
    && ./obj_dir/l2_cache_sim; } > sim.log 2>&1 \
    || echo "Something failed" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && { echo "simulation FAILED"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

//--- testbench/cache_input.txt
// columns: op addr wdata expected idle, all hex; idle cycles follow the op
// op: 0 idle only, 1 read, 2 write, 3 read that must hit, 4 memory word check, f end
0 0000 00000000 00000000 04
// read miss, then hit without memory traffic
1 1003 00000000 effc1003 00
3 1003 00000000 effc1003 00
// write allocate, memory keeps its old word
2 2005 cafe0001 00000000 00
4 2005 00000000 dffa2005 00
3 2005 00000000 cafe0001 00
// all four ways of set 7, dirty
2 1007 11110007 00000000 00
2 2007 22220007 00000000 00
2 3007 33330007 00000000 00
2 4007 44440007 00000000 00
// fifth tag, plru 111 picks way 0 so 1007 goes to the buffer
2 5007 55550007 00000000 00
4 1007 00000000 eff81007 00
1 1007 00000000 11110007 00
2 1007 1111aaaa 00000000 00
1 1007 00000000 1111aaaa 14
// drained after the idle stretch
4 1007 00000000 1111aaaa 00
// refetch from memory, plru 001 evicts way 2 (3007)
1 1007 00000000 1111aaaa 00
1 3007 00000000 33330007 00
// buffer full, plru 100 picks way 1 (2007), drain goes first
2 6007 66660007 00000000 00
4 3007 00000000 33330007 00
1 2007 00000000 22220007 00
3 6007 00000000 66660007 00
3 5007 00000000 55550007 00
4 2007 00000000 dff82007 14
4 2007 00000000 22220007 00
3 1007 00000000 1111aaaa 00
// plru 100 again, way 1 (6007) evicted
2 7007 77770007 00000000 00
1 6007 00000000 66660007 00
3 7007 00000000 77770007 14
4 6007 00000000 66660007 00
4 7007 00000000 8ff87007 00
f 0000 00000000 00000000 00
